// ==== bench/spi_cmd_master_sva.sv ====
`timescale 1ns/1ps

module spi_cmd_master_sva (
  input logic clk,
  input logic rst_n,
  input logic sclk,
  input logic cs_n,
  input logic cmd_rdy,
  input logic read_vld
);

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk)
    else $error("sclk high while cs_n is high");

  a_busy: assert property (@(posedge clk) disable iff (!rst_n)
    !cs_n |-> !cmd_rdy)
    else $error("cmd_rdy high during a frame");

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld longer than one cycle");

  // A frame only starts from idle.
  a_start: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cs_n) |-> $past(cmd_rdy))
    else $error("cs_n fell while busy");

endmodule

bind spi_cmd_master spi_cmd_master_sva u_sva (
  .clk      (clk),
  .rst_n    (rst_n),
  .sclk     (sclk),
  .cs_n     (cs_n),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

// ==== bench/spi_slave_model.sv ====
`timescale 1ns/1ps

module spi_slave_model (
  input  logic        rst_n,
  input  logic        sclk,
  input  logic        cs_n,
  input  logic        mosi,
  output logic        miso,
  output logic [11:0] frame_word,
  output int          frame_cnt
);

  logic [7:0]  regs [8];
  logic [11:0] rx_sr;
  logic [2:0]  addr;
  int          bit_cnt;

  // One block sees every edge, so the frame state has a single driver.
  always @(posedge sclk or negedge sclk or posedge cs_n or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] = 8'(i * 17);
      rx_sr      = '0;
      addr       = '0;
      bit_cnt    = 0;
      miso       = 1'b0;
      frame_word = '0;
      frame_cnt  = 0;
    end
    else if (cs_n)
    begin
      // End of frame, a write lands in the register file.
      if (bit_cnt == 12)
      begin
        frame_word = rx_sr;
        frame_cnt  = frame_cnt + 1;
        if (rx_sr[11])
          regs[rx_sr[10:8]] = rx_sr[7:0];
      end
      bit_cnt = 0;
      miso    = 1'b0;
    end
    else if (sclk)
    begin
      rx_sr = {rx_sr[10:0], mosi};
      if (bit_cnt == 3)
        addr = rx_sr[2:0];
      bit_cnt = bit_cnt + 1;
    end
    else
    begin
      // Read data goes out after the flag and the address.
      if (bit_cnt >= 4 && bit_cnt < 12)
        miso = regs[addr][11 - bit_cnt];
      else
        miso = 1'b0;
    end
  end

endmodule

// ==== bench/tb_spi_cmd_master.sv ====
`timescale 1ns/1ps

module tb_spi_cmd_master
  import spi_types_pkg::*;
;

  localparam int MAX_CYCLES = 20000;

  logic       clk;
  logic       rst_n;
  cmd_word_t  cmd_in;
  logic       cmd_vld;
  logic       miso;
  logic       cmd_rdy;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       read_vld;
  read_byte_t read_data;
  logic [11:0] frame_word;
  int          frame_cnt;

  read_byte_t shadow [8];
  read_byte_t exp_q [$];
  int         seed;
  int         cycles;
  int         errors;
  int         checks;
  int         accepted;
  int         cs_falls;
  int         test_err0;
  int         test_chk0;
  int         frames0;

  spi_cmd_master #(
    .CLK_DIV (4)
  ) UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .frame_word (frame_word),
    .frame_cnt  (frame_cnt)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, the DUT stopped responding.", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  always @(negedge cs_n)
  begin
    if (rst_n)
      cs_falls++;
  end

  // Returns the byte a read gives back and applies a write to the shadow registers.
  function read_byte_t model_cmd(input cmd_word_t cmd);
    read_byte_t r;
    r = shadow[cmd[10:8]];
    if (cmd[WRITE_BIT])
      shadow[cmd[10:8]] = cmd[7:0];
    return r;
  endfunction

  task automatic check_value(input string name, input int exp, input int got);
    checks++;
    assert (exp == got)
    else
    begin
      $display("Error: time %0t, %s expected %0h, got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  // Compare each read result while it is stable.
  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        $display("Unexpected read_vld pulse with no read outstanding at %0t", $time);
        errors++;
      end
      if (exp_q.size() != 0)
        check_value("read_data", exp_q.pop_front(), read_data);
    end
  end

  task automatic issue(input cmd_word_t cmd);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    do @(negedge clk); while (!cmd_rdy);
    @(posedge clk);
    cmd_vld <= 1'b0;
    accepted++;
    if (!cmd[WRITE_BIT])
      exp_q.push_back(model_cmd(cmd));
    else
      void'(model_cmd(cmd));
  endtask

  task automatic wait_idle(input cmd_word_t cmd);
    do @(negedge clk); while (!cmd_rdy);
    check_value("frame_word", cmd[WRITE_BIT] ? cmd : {cmd[11:8], 8'h00}, frame_word);
    @(posedge clk);
  endtask

  task automatic run_cmd(input cmd_word_t cmd);
    issue(cmd);
    wait_idle(cmd);
  endtask

  task automatic start_test;
    test_err0 = errors;
    test_chk0 = checks;
  endtask

  task automatic finish_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, checks - test_chk0,
             errors - test_err0);
  endtask

  initial
  begin
    clk      = 1'b0;
    rst_n    = 1'b1;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    seed     = 48;
    cycles   = 0;
    errors   = 0;
    checks   = 0;
    accepted = 0;
    cs_falls = 0;
    for (int i = 0; i < 8; i++)
      shadow[i] = 8'(i * 17);
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    start_test();
    @(negedge clk);
    check_value("cs_n", 1, cs_n);
    check_value("sclk", 0, sclk);
    check_value("cmd_rdy", 1, cmd_rdy);
    check_value("read_vld", 0, read_vld);
    @(posedge clk);
    finish_test("reset");

    start_test();
    for (int a = 0; a < 8; a++)
      run_cmd({1'b0, 3'(a), 8'h00});
    finish_test("reset_reads");

    start_test();
    for (int a = 0; a < 8; a++)
      run_cmd({1'b1, 3'(7 - a), 8'(a * 37 + 5)});
    finish_test("writes");

    start_test();
    for (int n = 0; n < 40; n++)
      run_cmd(cmd_word_t'($random(seed)));
    finish_test("random");

    // A second command waits on cmd_vld through the whole first frame.
    start_test();
    frames0 = frame_cnt;
    cmd_in  <= {1'b1, 3'd2, 8'h5a};
    cmd_vld <= 1'b1;
    do @(negedge clk); while (!cmd_rdy);
    @(posedge clk);
    accepted++;
    void'(model_cmd({1'b1, 3'd2, 8'h5a}));
    cmd_in <= {1'b0, 3'd2, 8'h00};
    do
    begin
      @(negedge clk);
      check_value("cs_falls", accepted, cs_falls);
    end
    while (!cmd_rdy);
    check_value("frame_cnt", frames0 + 1, frame_cnt);
    @(posedge clk);
    cmd_vld <= 1'b0;
    accepted++;
    exp_q.push_back(model_cmd({1'b0, 3'd2, 8'h00}));
    wait_idle({1'b0, 3'd2, 8'h00});
    check_value("cs_falls", accepted, cs_falls);
    finish_test("busy");

    start_test();
    issue({1'b1, 3'd6, 8'hc3});
    run_cmd({1'b0, 3'd6, 8'h00});
    check_value("frame_cnt", accepted, frame_cnt);
    finish_test("back_to_back");

    repeat (4) @(posedge clk);
    check_value("pending_reads", 0, exp_q.size());
    $display("Done: %0d checks, %0d errors, %0d commands", checks, errors, accepted);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -f src.f --top-module tb_spi_cmd_master \
  -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

! grep -q ">>> FAIL" sim.log && grep -q ">>> PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== src.f ====
verilog/spi_types_pkg.sv
verilog/spi_fsm_pkg.sv
verilog/spi_sclk_timer.sv
verilog/spi_ctrl_fsm.sv
verilog/spi_shifter.sv
verilog/spi_cmd_master.sv
bench/spi_slave_model.sv
bench/spi_cmd_master_sva.sv
bench/tb_spi_cmd_master.sv

// ==== verilog/spi_cmd_master.sv ====
`timescale 1ns/1ps

module spi_cmd_master
  import spi_types_pkg::*, spi_fsm_pkg::*;
#(
  parameter int CLK_DIV = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_word_t  cmd_in,
  input  logic       cmd_vld,
  input  logic       miso,
  output logic       cmd_rdy,
  output logic       sclk,
  output logic       cs_n,
  output logic       mosi,
  output logic       read_vld,
  output read_byte_t read_data
);

  logic        run;
  logic        rise;
  logic        fall;
  logic        frame_end;
  shift_step_t step;

  spi_ctrl_fsm #(
    .CLK_DIV (CLK_DIV)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vld   (cmd_vld),
    .is_write  (cmd_in[WRITE_BIT]),
    .rise      (rise),
    .fall      (fall),
    .frame_end (frame_end),
    .cmd_rdy   (cmd_rdy),
    .run       (run),
    .cs_n      (cs_n),
    .step      (step),
    .read_vld  (read_vld)
  );

  spi_sclk_timer #(
    .CLK_DIV (CLK_DIV)
  ) u_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .sclk      (sclk),
    .rise      (rise),
    .fall      (fall),
    .frame_end (frame_end)
  );

  spi_shifter u_shifter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .step      (step),
    .miso      (miso),
    .mosi      (mosi),
    .read_data (read_data)
  );

endmodule

// ==== verilog/spi_ctrl_fsm.sv ====
`timescale 1ns/1ps

module spi_ctrl_fsm
  import spi_fsm_pkg::*;
#(
  parameter int CLK_DIV = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_vld,
  input  logic        is_write,
  input  logic        rise,
  input  logic        fall,
  input  logic        frame_end,
  output logic        cmd_rdy,
  output logic        run,
  output logic        cs_n,
  output shift_step_t step,
  output logic        read_vld
);

  localparam int PHASE_W = $clog2(CLK_DIV);
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(CLK_DIV - 1);

  ctrl_state_t        state;
  ctrl_state_t        state_nxt;
  logic [PHASE_W-1:0] phase;
  logic               phase_end;
  logic               write_q;
  logic               accept;

  assign cmd_rdy   = (state == ST_IDLE);
  assign accept    = cmd_rdy && cmd_vld;
  assign phase_end = (phase == PHASE_LAST);
  assign run       = (state == ST_SHIFT);

  // Select stays low from setup through hold.
  assign cs_n     = (state == ST_IDLE) || (state == ST_DONE);
  assign read_vld = (state == ST_DONE) && !write_q;

  assign step.load      = accept;
  assign step.keep_data = accept && is_write;
  assign step.shift     = fall;
  assign step.sample    = rise;
  // The last sample is already in by the final falling edge.
  assign step.capture   = frame_end && !write_q;

  always_comb
  begin
    state_nxt = state;
    case (state)
      ST_IDLE:
      begin
        if (accept)
          state_nxt = ST_SETUP;
      end
      ST_SETUP:
      begin
        if (phase_end)
          state_nxt = ST_SHIFT;
      end
      ST_SHIFT:
      begin
        if (frame_end)
          state_nxt = ST_HOLD;
      end
      ST_HOLD:
      begin
        if (phase_end)
          state_nxt = ST_DONE;
      end
      ST_DONE:
      begin
        state_nxt = ST_IDLE;
      end
      default:
      begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      phase   <= '0;
      write_q <= 1'b0;
    end
    else
    begin
      state <= state_nxt;

      // Setup and hold each last CLK_DIV cycles.
      if ((state == ST_SETUP || state == ST_HOLD) && !phase_end)
        phase <= phase + 1'b1;
      else
        phase <= '0;

      if (accept)
        write_q <= is_write;
    end
  end

endmodule

// ==== verilog/spi_fsm_pkg.sv ====
package spi_fsm_pkg;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT,
    ST_HOLD,
    ST_DONE
  } ctrl_state_t;

  // One-cycle strobes from the controller to the shifter.
  typedef struct packed {
    // Take a new command into the transmit register.
    logic load;
    // Keep the data field, zeros are loaded for a read.
    logic keep_data;
    // Advance the transmit register after a falling sclk edge.
    logic shift;
    // Take miso on a rising sclk edge.
    logic sample;
    // Copy the receive register to read_data.
    logic capture;
  } shift_step_t;

endpackage

// ==== verilog/spi_sclk_timer.sv ====
`timescale 1ns/1ps

module spi_sclk_timer
  import spi_types_pkg::*;
#(
  parameter int CLK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic rise,
  output logic fall,
  output logic frame_end
);

  localparam int HALF_W = $clog2(CLK_DIV);
  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(CLK_DIV - 1);
  localparam bit_count_t LAST_BIT = bit_count_t'(CMD_W - 1);

  logic [HALF_W-1:0] half_cnt;
  bit_count_t        bit_cnt;
  logic              toggle;

  // The strobes mark the cycle whose closing edge toggles sclk.
  assign toggle    = run && (half_cnt == HALF_LAST);
  assign rise      = toggle && !sclk;
  assign fall      = toggle && sclk;
  assign frame_end = fall && (bit_cnt == LAST_BIT);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
    end
    else if (!run)
    begin
      half_cnt <= '0;
      bit_cnt  <= '0;
      sclk     <= 1'b0;
    end
    else
    begin
      if (toggle)
      begin
        half_cnt <= '0;
        sclk     <= !sclk;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end

      // One bit per full sclk period, counted at its falling edge.
      if (frame_end)
      begin
        bit_cnt <= '0;
      end
      else if (fall)
      begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/spi_shifter.sv ====
`timescale 1ns/1ps

module spi_shifter
  import spi_types_pkg::*, spi_fsm_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  cmd_word_t   cmd_in,
  input  shift_step_t step,
  input  logic        miso,
  output logic        mosi,
  output read_byte_t  read_data
);

  cmd_word_t  tx_q;
  read_byte_t rx_q;

  // MSB first, so the flag is on the line from the load onward.
  assign mosi = tx_q[CMD_W-1];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_q <= '0;
    end
    else if (step.load)
    begin
      if (step.keep_data)
        tx_q <= cmd_in;
      else
        tx_q <= {cmd_in[CMD_W-1:READ_W], {READ_W{1'b0}}};
    end
    else if (step.shift)
    begin
      // Zeros follow, mosi idles low after the frame.
      tx_q <= {tx_q[CMD_W-2:0], 1'b0};
    end
  end

  // Twelve bits pass through, the last eight remain.
  always_ff @(posedge clk)
  begin
    if (step.sample)
      rx_q <= {rx_q[READ_W-2:0], miso};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      read_data <= '0;
    end
    else if (step.capture)
    begin
      read_data <= rx_q;
    end
  end

endmodule

// ==== verilog/spi_types_pkg.sv ====
package spi_types_pkg;

  // Read byte, also the data field of a write command.
  localparam int READ_W = 8;

  // Register address, bits 10 to 8 of the command.
  localparam int ADDR_W = 3;

  // Flag, address and data make up one command word.
  localparam int CMD_W = 1 + ADDR_W + READ_W;

  // Bit 11 set means write.
  localparam int WRITE_BIT = CMD_W - 1;

  typedef logic [CMD_W-1:0] cmd_word_t;

  typedef logic [READ_W-1:0] read_byte_t;

  // Index of the bit within a frame.
  typedef logic [$clog2(CMD_W)-1:0] bit_count_t;

endpackage
